// ==== Makefile ====
# Verilator build and run of the SFU testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= sfu_unit_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/sfu_unit_sva.sv ====
/*
 * Concurrent assertions on the SFU top level handshakes and warp control pulse.
 * Bound to every sfu_unit instance by the bind statement at the end of this file.
 */
`timescale 1ns/1ps

module sfu_unit_sva
    import sfu_op_pkg::*;
    import sfu_pipe_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        exec_valid,
    input sfu_exec_t   exec,
    input logic        exec_ready,
    input logic        commit_valid,
    input sfu_commit_t commit,
    input logic        commit_ready,
    input logic        warp_ctl_valid
);
    logic wctl_accept;

    assign wctl_accept = exec_valid && exec_ready &&
        !(exec.op inside {SFU_OP_CSRRW, SFU_OP_CSRRS, SFU_OP_CSRRC});

    // A stalled commit keeps its valid and its payload
    commit_hold: assert property (@(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit))
        else $error("commit dropped or changed while commit_ready was low");

    // Each pulse belongs to exactly one accepted warp control request
    pulse_single: assert property (@(posedge clk) disable iff (reset)
        warp_ctl_valid |-> $past(wctl_accept))
        else $error("warp control pulse without a matching request");

    reset_quiet: assert property (@(posedge clk) reset |=> !commit_valid)
        else $error("commit_valid high after a reset cycle");

endmodule

bind sfu_unit sfu_unit_sva i_sfu_unit_sva (
    .clk            (clk),
    .reset          (reset),
    .exec_valid     (exec_valid),
    .exec           (exec),
    .exec_ready     (exec_ready),
    .commit_valid   (commit_valid),
    .commit         (commit),
    .commit_ready   (commit_ready),
    .warp_ctl_valid (warp_ctl_valid)
);

// ==== dv/sfu_unit_tb.sv ====
/*
 * Testbench of the SFU top level. Sends LFSR generated warp control and CSR requests
 * under random commit back-pressure and checks every commit and warp control event
 * against a reference model kept here.
 */
`timescale 1ns/1ps
`include "sfu_cfg.svh"

module sfu_unit_tb
    import sfu_op_pkg::*;
    import sfu_pipe_pkg::*;
();
    localparam int NUM_REQ = 400;
    localparam int LAT_REQ = 8;
    localparam int RESET_CYCLES = 5;
    localparam int TIMEOUT_CYCLES = NUM_REQ * 8 + RESET_CYCLES;
    localparam int NUM_TAGS = 1 << `SFU_UUID_BITS;

    logic        clk;
    logic        reset;
    logic        exec_valid;
    sfu_exec_t   exec;
    logic        exec_ready;
    logic [1:0]  instret_inc;
    logic        commit_valid;
    sfu_commit_t commit;
    logic        commit_ready;
    logic        warp_ctl_valid;
    warp_ctl_t   warp_ctl;

    logic [31:0]          lfsr = 32'h857e_e29d;
    int                   cycle_count;
    int                   timeout_count;
    int                   sent;
    int                   outstanding;
    logic                 exec_taken;
    logic [31:0]          instret_sum;
    logic [`SFU_XLEN-1:0] scratch_model [`SFU_NUM_WARPS];
    sfu_commit_t          exp_commit [NUM_TAGS];
    logic                 pending [NUM_TAGS];
    logic                 lat_check [NUM_TAGS];
    int                   accept_cycle [NUM_TAGS];
    warp_ctl_t            exp_ctl_q [$];

    sfu_unit i_sfu_unit (
        .clk            (clk),
        .reset          (reset),
        .exec_valid     (exec_valid),
        .exec           (exec),
        .exec_ready     (exec_ready),
        .instret_inc    (instret_inc),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .commit_ready   (commit_ready),
        .warp_ctl_valid (warp_ctl_valid),
        .warp_ctl       (warp_ctl)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR stepped once per returned bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        lsb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lsb = lfsr[0];
            lfsr = (lfsr >> 1) ^ (lsb ? 32'h8020_0003 : 32'h0);
            val = {val[30:0], lsb};
        end
        return val;
    endfunction

    function automatic sfu_op_e pick_op(input logic [2:0] sel);
        case (sel)
            3'd0: return SFU_OP_TMC;
            3'd1: return SFU_OP_WSPAWN;
            3'd2: return SFU_OP_BAR;
            3'd3, 3'd6: return SFU_OP_CSRRW;
            3'd4, 3'd7: return SFU_OP_CSRRS;
            default: return SFU_OP_CSRRC;
        endcase
    endfunction

    // Address 7 is outside the map and reads as zero
    function automatic csr_addr_e pick_csr(input logic [2:0] sel);
        case (sel)
            3'd0, 3'd6: return CSR_SCRATCH;
            3'd1: return CSR_MCYCLE;
            3'd2: return CSR_MINSTRET;
            3'd3: return CSR_CORE_ID;
            3'd4: return CSR_WARP_ID;
            3'd5: return CSR_THREAD_ID;
            default: return csr_addr_e'(12'h7c0);
        endcase
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_commit(input sfu_commit_t got, input sfu_commit_t want);
        if (got !== want) begin
            abort_run($sformatf("Fail at %0t: commit uuid %0h got %h expected %h",
                $time, want.uuid, got, want));
        end
    endtask

    task automatic check_warp_ctl(input warp_ctl_t got, input warp_ctl_t want);
        if (got !== want) begin
            abort_run($sformatf("Fail at %0t: warp control got %h expected %h",
                $time, got, want));
        end
    endtask

    task automatic check_latency(input int got, input int want, input int tag);
        if (got != want) begin
            abort_run($sformatf("Fail at %0t: uuid %0h committed after %0d cycles, expected %0d",
                $time, tag, got, want));
        end
    endtask

    task automatic make_request();
        logic [31:0] r;
        r = rand_bits(`SFU_WID_BITS);
        exec.wid = r[`SFU_WID_BITS-1:0];
        r = rand_bits(`SFU_NUM_LANES);
        exec.tmask = r[`SFU_NUM_LANES-1:0];
        exec.pc = rand_bits(32);
        r = rand_bits(3);
        exec.op = pick_op(r[2:0]);
        r = rand_bits(3);
        exec.csr_addr = pick_csr(r[2:0]);
        r = rand_bits(`SFU_REG_BITS);
        exec.rd = r[`SFU_REG_BITS-1:0];
        r = rand_bits(1);
        exec.wb = r[0];
        exec.uuid = sent[`SFU_UUID_BITS-1:0];
        for (int i = 0; i < `SFU_NUM_LANES; i++) begin
            exec.rs1_data[i] = rand_bits(`SFU_XLEN);
        end
    endtask

    // Reference model step for one accepted request
    task automatic record_accept();
        sfu_commit_t          want;
        warp_ctl_t            ctl;
        logic [`SFU_XLEN-1:0] operand;
        logic [`SFU_XLEN-1:0] rdata;
        logic [`SFU_XLEN-1:0] bar;
        logic                 found;
        int                   tag;
        tag = int'(exec.uuid);
        if (pending[tag]) begin
            abort_run($sformatf("Request tag %0h was reused before its commit arrived", tag));
        end
        want = '0;
        want.uuid = exec.uuid;
        want.wid = exec.wid;
        want.tmask = exec.tmask;
        want.pc = exec.pc;
        want.rd = exec.rd;
        if (exec.op inside {SFU_OP_CSRRW, SFU_OP_CSRRS, SFU_OP_CSRRC}) begin
            operand = '0;
            found = 1'b0;
            for (int i = 0; i < `SFU_NUM_LANES; i++) begin
                if (exec.tmask[i] && !found) begin
                    operand = exec.rs1_data[i];
                    found = 1'b1;
                end
            end
            case (exec.csr_addr)
                CSR_SCRATCH:  rdata = scratch_model[exec.wid];
                CSR_MCYCLE:   rdata = `SFU_XLEN'(cycle_count);
                CSR_MINSTRET: rdata = instret_sum;
                CSR_CORE_ID:  rdata = `SFU_XLEN'(`SFU_CORE_ID);
                CSR_WARP_ID:  rdata = `SFU_XLEN'(exec.wid);
                default:      rdata = '0;
            endcase
            for (int i = 0; i < `SFU_NUM_LANES; i++) begin
                if (exec.tmask[i]) begin
                    want.data[i] = (exec.csr_addr == CSR_THREAD_ID) ? `SFU_XLEN'(i) : rdata;
                end
            end
            want.wb = exec.wb;
            if (exec.csr_addr == CSR_SCRATCH) begin
                case (exec.op)
                    SFU_OP_CSRRW: scratch_model[exec.wid] = operand;
                    SFU_OP_CSRRS: scratch_model[exec.wid] |= operand;
                    default:      scratch_model[exec.wid] &= ~operand;
                endcase
            end
        end else begin
            ctl = '0;
            ctl.wid = exec.wid;
            ctl.op = exec.op;
            bar = exec.rs1_data[0] % `SFU_NUM_BARRIERS;
            case (exec.op)
                SFU_OP_TMC: ctl.tmask = exec.rs1_data[0][`SFU_NUM_LANES-1:0];
                SFU_OP_WSPAWN: begin
                    ctl.spawn_mask = exec.rs1_data[0][`SFU_NUM_WARPS-1:0];
                    ctl.spawn_pc = exec.rs1_data[1];
                end
                default: begin
                    ctl.bar_id = bar[`SFU_BAR_BITS-1:0];
                    ctl.bar_count = exec.rs1_data[1][`SFU_WID_BITS:0];
                end
            endcase
            exp_ctl_q.push_back(ctl);
        end
        exp_commit[tag] = want;
        pending[tag] = 1'b1;
        lat_check[tag] = (sent < LAT_REQ);
        accept_cycle[tag] = cycle_count;
        outstanding++;
        sent++;
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        logic        lat_phase;
        logic        go;
        r = rand_bits(2);
        instret_inc = r[1:0];
        // Early requests run one at a time on an idle unit to measure latency
        lat_phase = (sent < LAT_REQ) || (sent == LAT_REQ && outstanding > 0);
        if (lat_phase) begin
            commit_ready = 1'b1;
        end else begin
            r = rand_bits(2);
            commit_ready = (r[1:0] != 2'b00);
        end
        if (!(exec_valid && !exec_taken)) begin
            exec_valid = 1'b0;
            if (sent < NUM_REQ) begin
                r = rand_bits(2);
                go = lat_phase ? (outstanding == 0) : (r[1:0] != 2'b00);
                if (go) begin
                    make_request();
                    exec_valid = 1'b1;
                end
            end
        end
    endtask

    // Runs at the falling edge, where inputs and registers are settled
    task automatic sample_outputs();
        int        tag;
        warp_ctl_t want_ctl;
        exec_taken = exec_valid && exec_ready;
        if (exec_taken) begin
            record_accept();
        end
        if (commit_valid && commit_ready) begin
            tag = int'(commit.uuid);
            if (!pending[tag]) begin
                abort_run($sformatf("Commit with uuid %0h arrived with no request waiting for it",
                    tag));
            end
            check_commit(commit, exp_commit[tag]);
            if (lat_check[tag]) begin
                check_latency(cycle_count - accept_cycle[tag], 2, tag);
            end
            pending[tag] = 1'b0;
            outstanding--;
        end
        if (warp_ctl_valid) begin
            if (exp_ctl_q.size() == 0) begin
                abort_run("A warp control event appeared with no warp control request pending");
            end
            want_ctl = exp_ctl_q.pop_front();
            check_warp_ctl(warp_ctl, want_ctl);
        end
        instret_sum += 32'(instret_inc);
    endtask

    initial begin
        timeout_count = 0;
        forever begin
            @(posedge clk);
            timeout_count++;
            if (timeout_count > TIMEOUT_CYCLES) begin
                $display("Timeout after %0d cycles, %0d requests sent, %0d commits missing",
                    timeout_count, sent, outstanding);
                $display("*** TEST FAILED ***");
                $fatal(1, "timeout");
            end
        end
    end

    initial begin
        int remaining;
        reset = 1'b1;
        exec_valid = 1'b0;
        exec = '0;
        instret_inc = 2'b00;
        commit_ready = 1'b0;
        exec_taken = 1'b0;
        cycle_count = 0;
        sent = 0;
        outstanding = 0;
        instret_sum = '0;
        for (int w = 0; w < `SFU_NUM_WARPS; w++) begin
            scratch_model[w] = '0;
        end
        for (int t = 0; t < NUM_TAGS; t++) begin
            pending[t] = 1'b0;
            lat_check[t] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        reset = 1'b0;

        while (sent < NUM_REQ || outstanding > 0 || exp_ctl_q.size() > 0) begin
            @(posedge clk);
            // MCYCLE advances on every edge out of reset
            cycle_count++;
            #10;
            drive_inputs();
            @(negedge clk);
            sample_outputs();
        end

        remaining = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (pending[t]) begin
                remaining++;
            end
        end
        if (remaining == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("%0d expected commits were never seen", remaining);
            $display("*** TEST FAILED ***");
            $fatal(1, "commits missing at the end of the run");
        end
    end

endmodule

// ==== verilog/sfu_cfg.svh ====
/*
 * Build-time sizes of the special function unit.
 * Included by the packages and by every module that sizes logic from these values.
 */
`ifndef SFU_CFG_SVH
`define SFU_CFG_SVH

// Threads per warp and warps per core
`define SFU_NUM_LANES 4
`define SFU_NUM_WARPS 4

`define SFU_XLEN 32
`define SFU_CORE_ID 0
`define SFU_UUID_BITS 8
`define SFU_NUM_BARRIERS 4

// Widths derived from the sizes above
`define SFU_WID_BITS ($clog2(`SFU_NUM_WARPS))
`define SFU_BAR_BITS ($clog2(`SFU_NUM_BARRIERS))
`define SFU_REG_BITS 5

`endif

// ==== verilog/sfu_csr_unit.sv ====
/*
 * CSR PE. Holds the per-warp scratch registers and the cycle and retired counters,
 * and executes read-write, read-set and read-clear requests on them.
 */
`timescale 1ns/1ps
`include "sfu_cfg.svh"

module sfu_csr_unit
    import sfu_op_pkg::*;
    import sfu_pipe_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  logic        exec_valid,
    input  sfu_exec_t   exec,
    output logic        exec_ready,

    input  logic [1:0]  instret_inc,

    output logic        commit_valid,
    output sfu_commit_t commit,
    input  logic        commit_ready
);
    logic [`SFU_XLEN-1:0] scratch [`SFU_NUM_WARPS];
    logic [`SFU_XLEN-1:0] mcycle;
    logic [`SFU_XLEN-1:0] minstret;
    logic [`SFU_XLEN-1:0] csr_rdata;
    logic [`SFU_XLEN-1:0] operand;
    logic [`SFU_XLEN-1:0] scratch_next;
    lane_data_t           lane_rdata;
    logic                 accept;

    assign exec_ready = !commit_valid || commit_ready;
    assign accept = exec_valid && exec_ready;

    // Write operand comes from the lowest active lane
    always_comb begin
        operand = '0;
        for (int i = `SFU_NUM_LANES - 1; i >= 0; i--) begin
            if (exec.tmask[i]) begin
                operand = exec.rs1_data[i];
            end
        end
    end

    // Reads see the value before this request's write
    always_comb begin
        case (exec.csr_addr)
            CSR_SCRATCH:  csr_rdata = scratch[exec.wid];
            CSR_MCYCLE:   csr_rdata = mcycle;
            CSR_MINSTRET: csr_rdata = minstret;
            CSR_CORE_ID:  csr_rdata = `SFU_XLEN'(`SFU_CORE_ID);
            CSR_WARP_ID:  csr_rdata = `SFU_XLEN'(exec.wid);
            default:      csr_rdata = '0;
        endcase
    end

    always_comb begin
        for (int i = 0; i < `SFU_NUM_LANES; i++) begin
            if (!exec.tmask[i]) begin
                lane_rdata[i] = '0;
            end else if (exec.csr_addr == CSR_THREAD_ID) begin
                lane_rdata[i] = `SFU_XLEN'(i);
            end else begin
                lane_rdata[i] = csr_rdata;
            end
        end
    end

    always_comb begin
        case (exec.op)
            SFU_OP_CSRRW: scratch_next = operand;
            SFU_OP_CSRRS: scratch_next = scratch[exec.wid] | operand;
            SFU_OP_CSRRC: scratch_next = scratch[exec.wid] & ~operand;
            default:      scratch_next = scratch[exec.wid];
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle <= '0;
            minstret <= '0;
            commit_valid <= 1'b0;
            for (int w = 0; w < `SFU_NUM_WARPS; w++) begin
                scratch[w] <= '0;
            end
        end else begin
            mcycle <= mcycle + 1'b1;
            minstret <= minstret + `SFU_XLEN'(instret_inc);
            // Writes to read-only registers are dropped
            if (accept && (exec.csr_addr == CSR_SCRATCH)) begin
                scratch[exec.wid] <= scratch_next;
            end
            if (accept) begin
                commit_valid <= 1'b1;
            end else if (commit_ready) begin
                commit_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            commit.uuid <= exec.uuid;
            commit.wid <= exec.wid;
            commit.tmask <= exec.tmask;
            commit.pc <= exec.pc;
            commit.rd <= exec.rd;
            commit.wb <= exec.wb;
            commit.data <= lane_rdata;
        end
    end

endmodule

// ==== verilog/sfu_op_pkg.sv ====
/*
 * Operation codes, CSR address map and processing element indexes of the SFU.
 * Imported by the transport package and by the modules that decode operations.
 */
package sfu_op_pkg;

    // Warp control operations sit below 8, CSR operations at 8 and above
    typedef enum logic [3:0] {
        SFU_OP_TMC    = 4'h0,
        SFU_OP_WSPAWN = 4'h1,
        SFU_OP_BAR    = 4'h2,
        SFU_OP_CSRRW  = 4'h8,
        SFU_OP_CSRRS  = 4'h9,
        SFU_OP_CSRRC  = 4'ha
    } sfu_op_e;

    // Only SCRATCH is writable, the rest read only
    typedef enum logic [11:0] {
        CSR_SCRATCH   = 12'h340,
        CSR_MCYCLE    = 12'hb00,
        CSR_MINSTRET  = 12'hb02,
        CSR_THREAD_ID = 12'hcc0,
        CSR_WARP_ID   = 12'hcc1,
        CSR_CORE_ID   = 12'hcc2
    } csr_addr_e;

    // Processing elements behind the switch
    typedef enum logic [0:0] {
        PE_WCTL = 1'b0,
        PE_CSR  = 1'b1
    } pe_idx_e;

endpackage

// ==== verilog/sfu_pe_switch.sv ====
/*
 * Request router and commit arbiter of the SFU. Steers each request to the PE
 * that owns its opcode and merges the PE commits round-robin into one register.
 */
`timescale 1ns/1ps

module sfu_pe_switch
    import sfu_op_pkg::*;
    import sfu_pipe_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  logic        exec_valid,
    input  sfu_exec_t   exec,
    output logic        exec_ready,

    output logic        pe_exec_valid [2],
    output sfu_exec_t   pe_exec,
    input  logic        pe_exec_ready [2],

    input  logic        pe_commit_valid [2],
    input  sfu_commit_t pe_commit [2],
    output logic        pe_commit_ready [2],

    output logic        commit_valid,
    output sfu_commit_t commit,
    input  logic        commit_ready
);
    pe_idx_e pe_sel;
    pe_idx_e rr_ptr;
    pe_idx_e rr_other;
    pe_idx_e grant;
    logic    grant_valid;
    logic    out_free;

    always_comb begin
        case (exec.op)
            SFU_OP_CSRRW, SFU_OP_CSRRS, SFU_OP_CSRRC: pe_sel = PE_CSR;
            default: pe_sel = PE_WCTL;
        endcase
    end

    // The request path is not registered
    assign pe_exec = exec;
    assign pe_exec_valid[PE_WCTL] = exec_valid && (pe_sel == PE_WCTL);
    assign pe_exec_valid[PE_CSR]  = exec_valid && (pe_sel == PE_CSR);
    assign exec_ready = pe_exec_ready[pe_sel];

    assign out_free = !commit_valid || commit_ready;
    assign rr_other = pe_idx_e'(~rr_ptr);

    // rr_ptr names the PE that wins when both commits are waiting
    always_comb begin
        grant = rr_ptr;
        grant_valid = 1'b0;
        if (pe_commit_valid[rr_ptr]) begin
            grant_valid = 1'b1;
        end else if (pe_commit_valid[rr_other]) begin
            grant = rr_other;
            grant_valid = 1'b1;
        end
    end

    assign pe_commit_ready[PE_WCTL] = out_free && grant_valid && (grant == PE_WCTL);
    assign pe_commit_ready[PE_CSR]  = out_free && grant_valid && (grant == PE_CSR);

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
            rr_ptr <= PE_WCTL;
        end else begin
            if (out_free) begin
                commit_valid <= grant_valid;
            end
            if (out_free && grant_valid) begin
                rr_ptr <= pe_idx_e'(~grant);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_free && grant_valid) begin
            commit <= pe_commit[grant];
        end
    end

endmodule

// ==== verilog/sfu_pipe_pkg.sv ====
/*
 * Transport types of the SFU pipeline: execute requests, commit results and
 * warp control events. Compile after sfu_op_pkg.
 */
`include "sfu_cfg.svh"

package sfu_pipe_pkg;
    import sfu_op_pkg::*;

    // One data word per lane, lane 0 in the low bits
    typedef logic [`SFU_NUM_LANES-1:0][`SFU_XLEN-1:0] lane_data_t;

    typedef struct packed {
        logic [`SFU_UUID_BITS-1:0] uuid;
        logic [`SFU_WID_BITS-1:0]  wid;
        logic [`SFU_NUM_LANES-1:0] tmask;
        logic [`SFU_XLEN-1:0]      pc;
        sfu_op_e                   op;
        csr_addr_e                 csr_addr;
        logic [`SFU_REG_BITS-1:0]  rd;
        logic                      wb;
        lane_data_t                rs1_data;
    } sfu_exec_t;

    typedef struct packed {
        logic [`SFU_UUID_BITS-1:0] uuid;
        logic [`SFU_WID_BITS-1:0]  wid;
        logic [`SFU_NUM_LANES-1:0] tmask;
        logic [`SFU_XLEN-1:0]      pc;
        logic [`SFU_REG_BITS-1:0]  rd;
        logic                      wb;
        lane_data_t                data;
    } sfu_commit_t;

    // Fields that do not belong to op are zero
    typedef struct packed {
        logic [`SFU_WID_BITS-1:0]  wid;
        sfu_op_e                   op;
        logic [`SFU_NUM_LANES-1:0] tmask;
        logic [`SFU_NUM_WARPS-1:0] spawn_mask;
        logic [`SFU_XLEN-1:0]      spawn_pc;
        logic [`SFU_BAR_BITS-1:0]  bar_id;
        logic [`SFU_WID_BITS:0]    bar_count;
    } warp_ctl_t;

endpackage

// ==== verilog/sfu_unit.sv ====
/*
 * Top level of the special function unit for one issue slot.
 * Connects the request switch to the warp control and CSR processing elements.
 */
`timescale 1ns/1ps

module sfu_unit
    import sfu_op_pkg::*;
    import sfu_pipe_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  logic        exec_valid,
    input  sfu_exec_t   exec,
    output logic        exec_ready,

    input  logic [1:0]  instret_inc,

    output logic        commit_valid,
    output sfu_commit_t commit,
    input  logic        commit_ready,

    output logic        warp_ctl_valid,
    output warp_ctl_t   warp_ctl
);
    logic        pe_exec_valid [2];
    sfu_exec_t   pe_exec;
    logic        pe_exec_ready [2];
    logic        pe_commit_valid [2];
    sfu_commit_t pe_commit [2];
    logic        pe_commit_ready [2];

    sfu_pe_switch i_pe_switch (
        .clk             (clk),
        .reset           (reset),
        .exec_valid      (exec_valid),
        .exec            (exec),
        .exec_ready      (exec_ready),
        .pe_exec_valid   (pe_exec_valid),
        .pe_exec         (pe_exec),
        .pe_exec_ready   (pe_exec_ready),
        .pe_commit_valid (pe_commit_valid),
        .pe_commit       (pe_commit),
        .pe_commit_ready (pe_commit_ready),
        .commit_valid    (commit_valid),
        .commit          (commit),
        .commit_ready    (commit_ready)
    );

    sfu_wctl_unit i_wctl_unit (
        .clk            (clk),
        .reset          (reset),
        .exec_valid     (pe_exec_valid[PE_WCTL]),
        .exec           (pe_exec),
        .exec_ready     (pe_exec_ready[PE_WCTL]),
        .commit_valid   (pe_commit_valid[PE_WCTL]),
        .commit         (pe_commit[PE_WCTL]),
        .commit_ready   (pe_commit_ready[PE_WCTL]),
        .warp_ctl_valid (warp_ctl_valid),
        .warp_ctl       (warp_ctl)
    );

    sfu_csr_unit i_csr_unit (
        .clk          (clk),
        .reset        (reset),
        .exec_valid   (pe_exec_valid[PE_CSR]),
        .exec         (pe_exec),
        .exec_ready   (pe_exec_ready[PE_CSR]),
        .instret_inc  (instret_inc),
        .commit_valid (pe_commit_valid[PE_CSR]),
        .commit       (pe_commit[PE_CSR]),
        .commit_ready (pe_commit_ready[PE_CSR])
    );

endmodule

// ==== verilog/sfu_wctl_unit.sv ====
/*
 * Warp control PE. Executes thread mask change, warp spawn and barrier requests,
 * emits a one-cycle warp control event and commits without a register write.
 */
`timescale 1ns/1ps
`include "sfu_cfg.svh"

module sfu_wctl_unit
    import sfu_op_pkg::*;
    import sfu_pipe_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  logic        exec_valid,
    input  sfu_exec_t   exec,
    output logic        exec_ready,

    output logic        commit_valid,
    output sfu_commit_t commit,
    input  logic        commit_ready,

    output logic        warp_ctl_valid,
    output warp_ctl_t   warp_ctl
);
    logic                 accept;
    logic [`SFU_XLEN-1:0] bar_sel;
    warp_ctl_t            ctl_next;

    assign exec_ready = !commit_valid || commit_ready;
    assign accept = exec_valid && exec_ready;
    assign bar_sel = exec.rs1_data[0] % `SFU_NUM_BARRIERS;

    always_comb begin
        ctl_next = '0;
        ctl_next.wid = exec.wid;
        ctl_next.op = exec.op;
        case (exec.op)
            // A zero mask stops the warp
            SFU_OP_TMC: ctl_next.tmask = exec.rs1_data[0][`SFU_NUM_LANES-1:0];
            SFU_OP_WSPAWN: begin
                ctl_next.spawn_mask = exec.rs1_data[0][`SFU_NUM_WARPS-1:0];
                ctl_next.spawn_pc = exec.rs1_data[1];
            end
            SFU_OP_BAR: begin
                ctl_next.bar_id = bar_sel[`SFU_BAR_BITS-1:0];
                ctl_next.bar_count = exec.rs1_data[1][`SFU_WID_BITS:0];
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
            warp_ctl_valid <= 1'b0;
        end else begin
            warp_ctl_valid <= accept;
            if (accept) begin
                commit_valid <= 1'b1;
            end else if (commit_ready) begin
                commit_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            commit.uuid <= exec.uuid;
            commit.wid <= exec.wid;
            commit.tmask <= exec.tmask;
            commit.pc <= exec.pc;
            commit.rd <= exec.rd;
            commit.wb <= 1'b0;
            commit.data <= '0;
            warp_ctl <= ctl_next;
        end
    end

endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/sfu_op_pkg.sv
verilog/sfu_pipe_pkg.sv
verilog/sfu_pe_switch.sv
verilog/sfu_wctl_unit.sv
verilog/sfu_csr_unit.sv
verilog/sfu_unit.sv
dv/sfu_unit_sva.sv
dv/sfu_unit_tb.sv
